//--- logic/hist_params.svh
`ifndef HIST_PARAMS_SVH
`define HIST_PARAMS_SVH

// array geometry
`define PIXEL_NUM 4
`define BIN_NUM 16

// raw event timestamp in TDC ticks
`define TIME_W 10
// windowed time to bin index
`define BIN_SHIFT 2

// bin counters saturate at all ones
`define COUNT_W 8
`define PIX_W 2
`define BIN_W 4
// pixel index above bin index
`define RAM_ADDR 6

// dropped event counter
`define DROP_W 16

// APB bus
`define APB_ADDR_W 8
`define APB_DATA_W 32

`endif

//--- logic/histPkg.sv
`include "hist_params.svh"

package histPkg;

    // one photon hit as delivered by the front end
    typedef struct packed {
        logic [`PIX_W-1:0]  pix;
        logic [`TIME_W-1:0] stamp;
    } photonEvent;

    // count RAM address, pixel in the upper bits
    typedef struct packed {
        logic [`PIX_W-1:0] pix;
        logic [`BIN_W-1:0] bin;
    } binReq;

    typedef logic [`COUNT_W-1:0] binCount;

    // scan result for one pixel
    // count sits in the low byte of the readout word
    typedef struct packed {
        logic [`BIN_W-1:0] bin;
        binCount           count;
    } peakEntry;

    // APB byte offsets
    localparam logic [`APB_ADDR_W-1:0] REG_CTRL   = 8'h00;
    localparam logic [`APB_ADDR_W-1:0] REG_STATUS = 8'h04;
    localparam logic [`APB_ADDR_W-1:0] REG_OFFSET = 8'h08;
    localparam logic [`APB_ADDR_W-1:0] REG_DROPS  = 8'h0C;
    // peak p at REG_PEAK0 + 4*p
    localparam logic [`APB_ADDR_W-1:0] REG_PEAK0  = 8'h10;

endpackage

//--- logic/histRam.sv
`timescale 1ns/100ps

module histRam #(
    parameter type wordT = logic [7:0],
    parameter int  DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     wrEn,
    input  logic [$clog2(DEPTH)-1:0] wrAddr,
    input  wordT                     wrData,
    input  logic                     rdEn,
    input  logic [$clog2(DEPTH)-1:0] rdAddr,
    output wordT                     rdData
);

    wordT mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // read port, one cycle latency
    // same-address write in the same cycle gives the old word
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

//--- logic/eventIngest.sv
`timescale 1ns/100ps
`include "hist_params.svh"

module eventIngest (
    input  logic                clk,
    input  logic                res,
    input  logic                evValid,
    output logic                evReady,
    input  histPkg::photonEvent evData,
    input  logic [`TIME_W-1:0]  windowOffset,
    input  logic                stall,
    output logic                reqValid,
    output histPkg::binReq      req,
    output logic [`DROP_W-1:0]  dropCount,
    input  logic                dropClear
);

    logic               accept;
    logic [`TIME_W-1:0] windowed;
    logic [`TIME_W-1:0] binFull;
    logic               early;
    logic               late;
    logic               drop;

    // only back-pressure point of the pipeline
    assign evReady = ~stall;
    assign accept  = evValid & evReady;

    // window rule on the incoming event
    assign early    = evData.stamp < windowOffset;
    assign windowed = evData.stamp - windowOffset;
    assign binFull  = windowed >> `BIN_SHIFT;
    // past the last bin
    assign late     = binFull >= `BIN_NUM;
    assign drop     = early | late;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            reqValid <= 1'b0;
        end else begin
            reqValid <= accept & ~drop;
        end
    end

    // bin address for the accumulator
    always_ff @(posedge clk) begin
        if (accept) begin
            req.pix <= evData.pix;
            req.bin <= binFull[`BIN_W-1:0];
        end
    end

    // drop counter, sticks at all ones
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dropCount <= '0;
        end else if (dropClear) begin
            dropCount <= '0;
        end else if (accept && drop && !(&dropCount)) begin
            dropCount <= dropCount + 1'b1;
        end
    end

    // stall comes from the accumulator and scanner
    reqNotStalled: assert property (
        @(posedge clk) disable iff (!res)
        $rose(reqValid) |-> !stall
    );

endmodule

//--- logic/binAccumulator.sv
`timescale 1ns/100ps
`include "hist_params.svh"

module binAccumulator (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 reqValid,
    input  histPkg::binReq       req,
    input  logic                 clearStart,
    output logic                 clearBusy,
    input  logic                 scanRdEn,
    input  logic [`RAM_ADDR-1:0] scanAddr,
    output histPkg::binCount     scanData
);
    import histPkg::*;

    localparam int DEPTH = `PIXEL_NUM * `BIN_NUM;

    // read stage, RAM word arrives here
    logic                 rdValid;
    binReq                rdReq;
    // write stage
    logic                 wrValid;
    binReq                wrReq;
    binCount              wrCount;
    // write that landed on the same edge as the read
    logic                 hazHit;
    binCount              hazCount;

    binCount              current;
    binCount              bumped;

    // clear sweep pointer
    logic [`RAM_ADDR-1:0] clrAddr;

    logic                 ramWrEn;
    logic [`RAM_ADDR-1:0] ramWrAddr;
    binCount              ramWrData;
    logic                 ramRdEn;
    logic [`RAM_ADDR-1:0] ramRdAddr;
    binCount              ramRdData;

    // scanner borrows the read port, events are stalled meanwhile
    assign ramRdEn   = reqValid | scanRdEn;
    assign ramRdAddr = scanRdEn ? scanAddr : {req.pix, req.bin};
    assign scanData  = ramRdData;

    // newest value wins: write stage, then the just-landed write, then RAM
    assign current = (wrValid && wrReq == rdReq) ? wrCount :
                     hazHit ? hazCount : ramRdData;
    // saturating increment
    assign bumped  = (&current) ? current : current + 1'b1;

    // clear sweep owns the write port while busy
    assign ramWrEn   = clearBusy | wrValid;
    assign ramWrAddr = clearBusy ? clrAddr : {wrReq.pix, wrReq.bin};
    assign ramWrData = clearBusy ? '0 : wrCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdValid <= 1'b0;
            wrValid <= 1'b0;
            hazHit  <= 1'b0;
        end else begin
            rdValid <= reqValid & ~clearBusy;
            wrValid <= rdValid & ~clearBusy;
            // read issued now misses the write going in now
            hazHit  <= reqValid & wrValid & (req == wrReq);
        end
    end

    // read-then-write pairing
    always_ff @(posedge clk) begin
        rdReq    <= req;
        wrReq    <= rdReq;
        wrCount  <= bumped;
        hazCount <= wrCount;
    end

    // zero every address, one per cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearBusy <= 1'b0;
            clrAddr   <= '0;
        end else if (clearStart) begin
            clearBusy <= 1'b1;
            clrAddr   <= '0;
        end else if (clearBusy) begin
            clrAddr <= clrAddr + 1'b1;
            if (clrAddr == `RAM_ADDR'(DEPTH - 1)) begin
                clearBusy <= 1'b0;
            end
        end
    end

    histRam #(
        .wordT (binCount),
        .DEPTH (DEPTH)
    ) countRam (
        .clk    (clk),
        .wrEn   (ramWrEn),
        .wrAddr (ramWrAddr),
        .wrData (ramWrData),
        .rdEn   (ramRdEn),
        .rdAddr (ramRdAddr),
        .rdData (ramRdData)
    );

    // both the sweep and the ingest path feed this address
    wrAddrInRange: assert property (
        @(posedge clk) disable iff (!res)
        ramWrEn |-> !$isunknown(ramWrAddr) && ramWrAddr < DEPTH
    );

endmodule

//--- logic/peakScanner.sv
`timescale 1ns/100ps
`include "hist_params.svh"

module peakScanner (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 scanStart,
    output logic                 scanBusy,
    output logic                 scanDone,
    output logic                 scanRdEn,
    output logic [`RAM_ADDR-1:0] scanAddr,
    input  histPkg::binCount     scanData,
    output logic                 peakWrEn,
    output logic [`PIX_W-1:0]    peakAddr,
    output histPkg::peakEntry    peakData
);
    import histPkg::*;

    localparam int DEPTH = `PIXEL_NUM * `BIN_NUM;

    // read issue side
    logic                 issuing;
    logic [`RAM_ADDR-1:0] rdAddr;
    // data side, one cycle behind
    logic                 dValid;
    binReq                dReq;
    // running maximum of the current pixel
    binCount              maxCount;
    logic [`BIN_W-1:0]    maxBin;
    logic                 take;
    binCount              candCount;
    logic [`BIN_W-1:0]    candBin;
    logic                 lastPeak;

    assign scanRdEn = issuing;
    assign scanAddr = rdAddr;

    // first bin seeds the max, later bins only on strictly greater
    // so a tie keeps the lower bin
    assign take      = (dReq.bin == '0) || (scanData > maxCount);
    assign candCount = take ? scanData : maxCount;
    assign candBin   = take ? dReq.bin : maxBin;

    assign lastPeak = peakWrEn && (peakAddr == `PIX_W'(`PIXEL_NUM - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            issuing  <= 1'b0;
            rdAddr   <= '0;
            dValid   <= 1'b0;
            peakWrEn <= 1'b0;
            scanBusy <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            dValid   <= issuing;
            // pixel's last bin closes its entry
            peakWrEn <= dValid && (dReq.bin == `BIN_W'(`BIN_NUM - 1));
            // one-cycle pulse after the final peak write
            scanDone <= lastPeak;
            if (scanStart) begin
                issuing  <= 1'b1;
                rdAddr   <= '0;
                scanBusy <= 1'b1;
            end else begin
                if (issuing) begin
                    rdAddr <= rdAddr + 1'b1;
                    if (rdAddr == `RAM_ADDR'(DEPTH - 1)) begin
                        issuing <= 1'b0;
                    end
                end
                if (lastPeak) begin
                    scanBusy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        dReq <= rdAddr;
        if (dValid) begin
            maxCount <= candCount;
            maxBin   <= candBin;
        end
        // peak RAM entry
        peakAddr       <= dReq.pix;
        peakData.bin   <= candBin;
        peakData.count <= candCount;
    end

    // software waits for the previous scan
    startWhenIdle: assert property (
        @(posedge clk) disable iff (!res)
        scanStart |-> !scanBusy
    );

endmodule

//--- logic/apbRegs.sv
`timescale 1ns/100ps
`include "hist_params.svh"

module apbRegs (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`APB_DATA_W-1:0] pwdata,
    output logic [`APB_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   clearStart,
    output logic                   scanStart,
    output logic [`TIME_W-1:0]     windowOffset,
    input  logic                   clearBusy,
    input  logic                   scanBusy,
    input  logic                   scanDone,
    input  logic [`DROP_W-1:0]     dropCount,
    output logic                   dropClear,
    output logic                   peakRdEn,
    output logic [`PIX_W-1:0]      peakRdAddr,
    input  histPkg::peakEntry      peakRdData
);
    import histPkg::*;

    localparam int PEAK_END = REG_PEAK0 + 4 * `PIXEL_NUM;

    logic                   setup;
    logic                   access;
    logic                   isPeak;
    logic                   mapped;
    logic                   wrCtrl;
    logic [`APB_ADDR_W-1:0] peakOff;
    // STATUS bit 2, held until the next start
    logic                   doneFlag;

    // no wait states
    assign pready = 1'b1;
    assign setup  = psel & ~penable;
    assign access = psel & penable;

    // peak window, word aligned
    assign peakOff = paddr - REG_PEAK0;
    assign isPeak  = (paddr >= REG_PEAK0) && (paddr < PEAK_END) && (paddr[1:0] == 2'b00);
    assign mapped  = isPeak || (paddr == REG_CTRL) || (paddr == REG_STATUS) ||
                     (paddr == REG_OFFSET) || (paddr == REG_DROPS);

    // peak RAM read in setup, word ready for the access phase
    assign peakRdEn   = setup & ~pwrite & isPeak;
    assign peakRdAddr = peakOff[`PIX_W+1:2];

    assign wrCtrl = access & pwrite & (paddr == REG_CTRL);

    // read mux, zero outside a read access
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (isPeak) begin
                prdata[$bits(peakEntry)-1:0] = peakRdData;
            end else begin
                case (paddr)
                    REG_STATUS: prdata[2:0] = {doneFlag, scanBusy, clearBusy};
                    REG_OFFSET: prdata[`TIME_W-1:0] = windowOffset;
                    REG_DROPS:  prdata[`DROP_W-1:0] = dropCount;
                    default:    prdata = '0;
                endcase
            end
        end
    end

    assign pslverr = access & ~mapped;

    // clear also resets the drop counter
    assign dropClear = clearStart;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearStart   <= 1'b0;
            scanStart    <= 1'b0;
            windowOffset <= '0;
            doneFlag     <= 1'b0;
        end else begin
            // start pulses last one cycle
            clearStart <= wrCtrl & pwdata[0];
            scanStart  <= wrCtrl & pwdata[1];
            if (access && pwrite && paddr == REG_OFFSET) begin
                windowOffset <= pwdata[`TIME_W-1:0];
            end
            if (clearStart || scanStart) begin
                doneFlag <= 1'b0;
            end else if (scanDone) begin
                doneFlag <= 1'b1;
            end
        end
    end

endmodule

//--- logic/histTop.sv
`timescale 1ns/100ps
`include "hist_params.svh"

module histTop (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   evValid,
    output logic                   evReady,
    input  histPkg::photonEvent    evData,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`APB_DATA_W-1:0] pwdata,
    output logic [`APB_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);
    import histPkg::*;

    logic                 stall;
    logic                 reqValid;
    binReq                req;
    logic                 clearStart;
    logic                 scanStart;
    logic                 dropClear;
    logic                 clearBusy;
    logic                 scanBusy;
    logic                 scanDone;
    logic [`TIME_W-1:0]   windowOffset;
    logic [`DROP_W-1:0]   dropCount;
    // scanner to count RAM
    logic                 scanRdEn;
    logic [`RAM_ADDR-1:0] scanAddr;
    binCount              scanData;
    // peak RAM ports
    logic                 peakWrEn;
    logic [`PIX_W-1:0]    peakWrAddr;
    peakEntry             peakWrData;
    logic                 peakRdEn;
    logic [`PIX_W-1:0]    peakRdAddr;
    peakEntry             peakRdData;

    // events wait during a clear or a scan
    assign stall = clearBusy | scanBusy;

    eventIngest ingest (
        .clk          (clk),
        .res          (res),
        .evValid      (evValid),
        .evReady      (evReady),
        .evData       (evData),
        .windowOffset (windowOffset),
        .stall        (stall),
        .reqValid     (reqValid),
        .req          (req),
        .dropCount    (dropCount),
        .dropClear    (dropClear)
    );

    binAccumulator accum (
        .clk        (clk),
        .res        (res),
        .reqValid   (reqValid),
        .req        (req),
        .clearStart (clearStart),
        .clearBusy  (clearBusy),
        .scanRdEn   (scanRdEn),
        .scanAddr   (scanAddr),
        .scanData   (scanData)
    );

    peakScanner scanner (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .scanBusy  (scanBusy),
        .scanDone  (scanDone),
        .scanRdEn  (scanRdEn),
        .scanAddr  (scanAddr),
        .scanData  (scanData),
        .peakWrEn  (peakWrEn),
        .peakAddr  (peakWrAddr),
        .peakData  (peakWrData)
    );

    histRam #(
        .wordT (peakEntry),
        .DEPTH (`PIXEL_NUM)
    ) peakRam (
        .clk    (clk),
        .wrEn   (peakWrEn),
        .wrAddr (peakWrAddr),
        .wrData (peakWrData),
        .rdEn   (peakRdEn),
        .rdAddr (peakRdAddr),
        .rdData (peakRdData)
    );

    apbRegs regs (
        .clk          (clk),
        .res          (res),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .clearStart   (clearStart),
        .scanStart    (scanStart),
        .windowOffset (windowOffset),
        .clearBusy    (clearBusy),
        .scanBusy     (scanBusy),
        .scanDone     (scanDone),
        .dropCount    (dropCount),
        .dropClear    (dropClear),
        .peakRdEn     (peakRdEn),
        .peakRdAddr   (peakRdAddr),
        .peakRdData   (peakRdData)
    );

endmodule

//--- test/histChecker.sv
`timescale 1ns/100ps
`include "hist_params.svh"

module histChecker (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic                   pready,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`APB_DATA_W-1:0] prdata,
    input  logic                   pslverr,
    input  logic                   evReady,
    input  logic                   expEn,
    input  logic [`APB_DATA_W-1:0] expData,
    input  logic                   expErr,
    input  logic                   readyCheck,
    input  logic                   readyExp,
    output int                     errCount,
    output int                     checkCount
);

    int   errs = 0;
    int   checks = 0;
    logic readDone;

    assign errCount   = errs;
    assign checkCount = checks;

    // completed read is an access phase with pready high
    assign readDone = res & psel & penable & pready & ~pwrite;

    // sampled on the falling edge once all drives have settled
    always @(negedge clk) begin
        // this slave never inserts wait states
        if (res && psel && penable) begin
            checks++;
            if (pready !== 1'b1) begin
                errs++;
                $display("ERROR %0t: pready low in the access phase at 0x%02h",
                         $time, paddr);
            end
        end
        if (readDone && expEn) begin
            checks++;
            if (prdata !== expData) begin
                errs++;
                $display("ERROR %0t: read of 0x%02h gave 0x%08h, expected 0x%08h",
                         $time, paddr, prdata, expData);
            end
            // unmapped addresses flag pslverr
            if (pslverr !== expErr) begin
                errs++;
                $display("ERROR %0t: read of 0x%02h gave pslverr %0b, expected %0b",
                         $time, paddr, pslverr, expErr);
            end
        end
        // event port back-pressure
        if (readyCheck) begin
            checks++;
            if (evReady !== readyExp) begin
                errs++;
                $display("ERROR %0t: evReady is %0b, expected %0b",
                         $time, evReady, readyExp);
            end
        end
    end

endmodule

//--- test/histTb.sv
`timescale 1ns/100ps
`include "hist_params.svh"

module histTb;
    import histPkg::*;

    localparam int DEPTH      = `PIXEL_NUM * `BIN_NUM;
    localparam int COUNT_MAX  = (1 << `COUNT_W) - 1;
    localparam int POLL_LIMIT = 100;

    logic                   clk;
    logic                   res;
    logic                   evValid;
    logic                   evReady;
    photonEvent             evData;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    // expected read value posted for the checker
    logic                   expEn;
    logic [`APB_DATA_W-1:0] expData;
    logic                   expErr;
    logic                   readyCheck;
    logic                   readyExp;
    int                     errCount;
    int                     checkCount;

    int                     seed;
    int                     timeouts;
    int                     failedTests;
    int                     errMark;
    photonEvent             evList[$];
    int                     expHist[DEPTH];
    int                     expBin[`PIXEL_NUM];
    int                     expCnt[`PIXEL_NUM];
    int                     expDrops;
    logic [`APB_DATA_W-1:0] rdVal;

    histTop dut (
        .clk     (clk),
        .res     (res),
        .evValid (evValid),
        .evReady (evReady),
        .evData  (evData),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    histChecker monitor (
        .clk        (clk),
        .res        (res),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pready     (pready),
        .paddr      (paddr),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .evReady    (evReady),
        .expEn      (expEn),
        .expData    (expData),
        .expErr     (expErr),
        .readyCheck (readyCheck),
        .readyExp   (readyExp),
        .errCount   (errCount),
        .checkCount (checkCount)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected histogram, peaks and drops for an event list
    function automatic int modelHistogram(input photonEvent evs[$], input int offset,
                                          output int hist[DEPTH],
                                          output int peakBin[`PIXEL_NUM],
                                          output int peakCnt[`PIXEL_NUM]);
        int drops;
        int wt;
        int a;
        drops = 0;
        foreach (hist[i]) begin
            hist[i] = 0;
        end
        foreach (evs[i]) begin
            wt = int'(evs[i].stamp) - offset;
            // below the offset or past the last bin
            if (wt < 0 || (wt >> `BIN_SHIFT) >= `BIN_NUM) begin
                drops++;
            end else begin
                a = int'(evs[i].pix) * `BIN_NUM + (wt >> `BIN_SHIFT);
                if (hist[a] < COUNT_MAX) begin
                    hist[a]++;
                end
            end
        end
        // strictly greater only, so ties keep the lowest bin
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            peakBin[p] = 0;
            peakCnt[p] = hist[p * `BIN_NUM];
            for (int b = 1; b < `BIN_NUM; b++) begin
                if (hist[p * `BIN_NUM + b] > peakCnt[p]) begin
                    peakBin[p] = b;
                    peakCnt[p] = hist[p * `BIN_NUM + b];
                end
            end
        end
        return drops;
    endfunction

    function automatic void addEvent(input int pix, input int stamp);
        photonEvent ev;
        ev.pix   = pix[`PIX_W-1:0];
        ev.stamp = stamp[`TIME_W-1:0];
        evList.push_back(ev);
    endfunction

    // access phase, held until pready
    task automatic finishAccess(output logic [`APB_DATA_W-1:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waited < POLL_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!pready) begin
            $display("timeout: APB access at 0x%02h never completed", paddr);
            timeouts++;
        end
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        expEn   <= 1'b0;
    endtask

    task automatic writeReg(input logic [`APB_ADDR_W-1:0] addr,
                            input logic [`APB_DATA_W-1:0] data);
        logic [`APB_DATA_W-1:0] unused;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        finishAccess(unused);
    endtask

    // chk posts exp and err for the checker
    task automatic readReg(input logic [`APB_ADDR_W-1:0] addr, input logic chk,
                           input logic [`APB_DATA_W-1:0] exp, input logic err,
                           output logic [`APB_DATA_W-1:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        expEn   <= chk;
        expData <= exp;
        expErr  <= err;
        finishAccess(data);
    endtask

    task automatic waitStatus(input int bitPos, input logic want, input string what);
        int                     polls;
        logic [`APB_DATA_W-1:0] st;
        polls = 0;
        readReg(REG_STATUS, 1'b0, '0, 1'b0, st);
        while (st[bitPos] != want && polls < POLL_LIMIT) begin
            polls++;
            readReg(REG_STATUS, 1'b0, '0, 1'b0, st);
        end
        if (st[bitPos] != want) begin
            $display("timeout: %s never happened", what);
            timeouts++;
        end
    endtask

    task automatic sendEvents(input int gapPct);
        int waited;
        @(posedge clk);
        foreach (evList[i]) begin
            evValid <= 1'b1;
            evData  <= evList[i];
            waited = 0;
            @(negedge clk);
            while (!evReady && waited < POLL_LIMIT) begin
                waited++;
                @(negedge clk);
            end
            if (!evReady) begin
                $display("timeout: event port never became ready");
                timeouts++;
            end
            // transfer edge
            @(posedge clk);
            if (($unsigned($random(seed)) % 100) < gapPct) begin
                evValid <= 1'b0;
                @(posedge clk);
            end
        end
        evValid <= 1'b0;
        // ingest, read and write stages drain
        repeat (4) @(posedge clk);
    endtask

    task automatic clearHist();
        writeReg(REG_CTRL, 32'h1);
        waitStatus(0, 1'b0, "end of clear sweep");
        readReg(REG_STATUS, 1'b1, 32'h0, 1'b0, rdVal);
    endtask

    task automatic runScan();
        writeReg(REG_CTRL, 32'h2);
        waitStatus(2, 1'b1, "scan done");
    endtask

    task automatic checkResults(input int offset);
        logic [`APB_DATA_W-1:0] exp;
        expDrops = modelHistogram(evList, offset, expHist, expBin, expCnt);
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            exp = `APB_DATA_W'((expBin[p] << `COUNT_W) | expCnt[p]);
            readReg(REG_PEAK0 + `APB_ADDR_W'(4 * p), 1'b1, exp, 1'b0, rdVal);
        end
        readReg(REG_DROPS, 1'b1, `APB_DATA_W'(expDrops), 1'b0, rdVal);
    endtask

    task automatic reportTest(input string name);
        int bad;
        bad = errCount + timeouts - errMark;
        if (bad == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failures", name, bad);
            failedTests++;
        end
        errMark = errCount + timeouts;
    endtask

    initial begin
        res         = 1'b0;
        evValid     = 1'b0;
        evData      = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        expEn       = 1'b0;
        expData     = '0;
        expErr      = 1'b0;
        readyCheck  = 1'b0;
        readyExp    = 1'b1;
        seed        = 32'h74ff;
        timeouts    = 0;
        failedTests = 0;
        errMark     = 0;
        repeat (4) @(posedge clk);
        res <= 1'b1;

        // empty histogram, every peak is bin 0 count 0
        evList.delete();
        clearHist();
        runScan();
        checkResults(0);
        reportTest("test 1 reset and clear");

        // random pixels, stamps 64 and up fall outside
        evList.delete();
        clearHist();
        writeReg(REG_OFFSET, 32'd0);
        repeat (300) begin
            addEvent($unsigned($random(seed)) % 4, $unsigned($random(seed)) % 80);
        end
        sendEvents(25);
        runScan();
        checkResults(0);
        reportTest("test 2 random burst");

        // back-to-back same bin, pixel 2 saturates
        evList.delete();
        clearHist();
        repeat (40) addEvent(1, 12);
        repeat (300) addEvent(2, 21);
        sendEvents(0);
        runScan();
        checkResults(0);
        reportTest("test 3 forwarding and saturation");

        // window 100 to 163
        evList.delete();
        clearHist();
        writeReg(REG_OFFSET, 32'd100);
        readReg(REG_OFFSET, 1'b1, 32'd100, 1'b0, rdVal);
        // pixel 0 ties between bin 7 and bin 2
        for (int k = 0; k < 3; k++) begin
            addEvent(0, 128 + k);
            addEvent(0, 108 + k);
        end
        repeat (40) begin
            addEvent(1, 60 + $unsigned($random(seed)) % 160);
        end
        repeat (2) addEvent(2, 100);
        addEvent(2, 99);
        for (int k = 0; k < 4; k++) begin
            addEvent(3, 160 + k);
        end
        repeat (2) addEvent(3, 164);
        sendEvents(25);
        runScan();
        checkResults(100);
        reportTest("test 4 offset window and ties");

        // unmapped and misaligned reads
        readReg(8'h40, 1'b1, 32'h0, 1'b1, rdVal);
        readReg(8'h06, 1'b1, 32'h0, 1'b1, rdVal);
        writeReg(REG_CTRL, 32'h2);
        readReg(REG_STATUS, 1'b1, 32'h2, 1'b0, rdVal);
        // scan still running here
        @(posedge clk);
        readyExp   <= 1'b0;
        readyCheck <= 1'b1;
        @(posedge clk);
        readyCheck <= 1'b0;
        waitStatus(2, 1'b1, "scan done");
        readReg(REG_STATUS, 1'b1, 32'h4, 1'b0, rdVal);
        reportTest("test 5 pslverr and stall");

        $display("tests 5, failed %0d, checks %0d, errors %0d, timeouts %0d",
                 failedTests, checkCount, errCount, timeouts);
        if (errCount == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/histPkg.sv
logic/histRam.sv
logic/eventIngest.sv
logic/binAccumulator.sv
logic/peakScanner.sv
logic/apbRegs.sv
logic/histTop.sv
test/histChecker.sv
test/histTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module histTb -o histSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/histSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
